//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // core word and cache line
  localparam int XLEN          = 32;
  localparam int LINE_BITS     = 128;

  // organisation, 2 ways of 16 sets
  localparam int WAYS          = 2;
  localparam int SETS          = 16;

  // address split, tag | index | offset
  localparam int OFFS_BITS     = 4;
  localparam int IDX_BITS      = 4;
  localparam int TAG_BITS      = 24;
  localparam int WORD_SEL_BITS = 2;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [IDX_BITS-1:0]  idx_t;
  typedef logic [LINE_BITS-1:0] line_t;

  // one bit per way, one-hot
  typedef logic [WAYS-1:0]      way_sel_t;

  // word read request, 30 bits
  typedef struct packed {
    tag_t                     tag;
    idx_t                     idx;
    logic [WORD_SEL_BITS-1:0] word_sel;
  } core_req_t;

  // fill command towards the cache memory, 31 bits
  typedef struct packed {
    logic     strobe;
    way_sel_t way;
    idx_t     idx;
    tag_t     tag;
  } fill_t;

  // split a byte address into tag, set and word in line
  // the two low bits are the byte in word and are dropped
  function automatic core_req_t to_core_req(logic [XLEN-1:0] addr);
    core_req_t req;
    req.tag      = addr[XLEN-1 -: TAG_BITS];
    req.idx      = addr[OFFS_BITS +: IDX_BITS];
    req.word_sel = addr[OFFS_BITS-1 -: WORD_SEL_BITS];
    return req;
  endfunction

endpackage

`default_nettype wire

//--- logic/cache_ram_1rw.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ram_1rw #(
  parameter type entry_t = logic
) (
  input  wire logic            clk_i,
  input  wire cache_pkg::idx_t addr_i,
  input  wire logic            we_i,
  input  wire entry_t          d_i,
  output      entry_t          q_o
);

  import cache_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage, one entry per set
  ////////////////////////////////////////////////////////////

  entry_t mem_q [SETS];

  // single port, one address for read and write
  // read returns the old entry on a write edge
  // new contents visible from the next read on
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem_q[addr_i] <= d_i;
    end
    // read every cycle, one cycle latency
    q_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

//--- logic/cache_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cache_memory (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,

  // lookup from the controller
  input  wire cache_pkg::core_req_t lookup_i,

  // fill command and line from the bus
  input  wire cache_pkg::fill_t     fill_i,
  input  wire cache_pkg::line_t     fill_line_i,

  input  wire logic                 flush_i,

  // registered lookup result
  output      logic                 hit_o,
  output      cache_pkg::way_sel_t  hit_way_o,
  output      cache_pkg::line_t     line_o
);

  import cache_pkg::*;

  ////////////////////////////////////////////////////////////
  // signals
  ////////////////////////////////////////////////////////////

  // ram address, shared by tag and data rams
  idx_t                     ram_idx;

  // lookup fields aligned with ram output
  idx_t                     idx_dly;
  tag_t                     tag_dly;

  // per way write enable during fill
  way_sel_t                 fill_we;
  logic                     fill_dly;

  // per way ram outputs
  tag_t                     tag_q  [WAYS];
  line_t                    data_q [WAYS];

  // valid bits in flops, way by set
  logic [WAYS-1:0][SETS-1:0] valid_q;

  // compare result and selected line
  way_sel_t                 way_hit;
  line_t                    line_mux;

  ////////////////////////////////////////////////////////////
  // index and tag handling
  ////////////////////////////////////////////////////////////

  // fill owns the rams while its strobe is high
  assign ram_idx = fill_i.strobe ? fill_i.idx : lookup_i.idx;

  // only the chosen victim way is written
  assign fill_we = {WAYS{fill_i.strobe}} & fill_i.way;

  // delay lookup fields by the ram latency
  always_ff @(posedge clk_i)
  begin
    idx_dly <= lookup_i.idx;
    tag_dly <= lookup_i.tag;
  end

  // remember a fill write for one cycle
  // ram output after a write edge is stale
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      fill_dly <= 1'b0;
    end
    else
    begin
      fill_dly <= fill_i.strobe;
    end
  end

  ////////////////////////////////////////////////////////////
  // per way rams
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    // tag ram
    cache_ram_1rw #(
      .entry_t ( tag_t       )
    ) u_tag_ram (
      .clk_i   ( clk_i       ),
      .addr_i  ( ram_idx     ),
      .we_i    ( fill_we[w]  ),
      .d_i     ( fill_i.tag  ),
      .q_o     ( tag_q[w]    )
    );

    // data ram, whole line per entry
    cache_ram_1rw #(
      .entry_t ( line_t      )
    ) u_data_ram (
      .clk_i   ( clk_i       ),
      .addr_i  ( ram_idx     ),
      .we_i    ( fill_we[w]  ),
      .d_i     ( fill_line_i ),
      .q_o     ( data_q[w]   )
    );

    // valid and tag match for this way
    assign way_hit[w] = valid_q[w][idx_dly] & (tag_q[w] == tag_dly);
  end

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  // flush wins over a fill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0;
    end
    else
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (fill_we[w])
        begin
          valid_q[w][fill_i.idx] <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // line select and output registers
  ////////////////////////////////////////////////////////////

  // and-or mux, at most one way hits
  always_comb
  begin
    line_mux = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      line_mux = line_mux | (data_q[w] & {LINE_BITS{way_hit[w]}});
    end
  end

  // hit blocked right after a fill write
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hit_o     <= 1'b0;
      hit_way_o <= '0;
    end
    else
    begin
      hit_o     <= (|way_hit) & ~fill_dly;
      hit_way_o <= way_hit & {WAYS{~fill_dly}};
    end
  end

  // line payload, only meaningful with hit_o
  always_ff @(posedge clk_i)
  begin
    line_o <= line_mux;
  end

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,

  // core side
  input  wire logic                        req_i,
  input  wire logic [cache_pkg::XLEN-1:0]  addr_i,
  input  wire logic                        flush_i,
  output      logic                        busy_o,
  output      logic                        rvalid_o,
  output      logic [cache_pkg::XLEN-1:0]  rdata_o,

  // cache memory side
  output      cache_pkg::core_req_t        lookup_o,
  output      cache_pkg::fill_t            fill_o,
  input  wire logic                        hit_i,
  input  wire cache_pkg::line_t            line_i,

  // bus side
  output      logic                        biu_req_o,
  output      logic [cache_pkg::XLEN-1:0]  biu_addr_o,
  input  wire logic                        biu_ack_i,
  input  wire cache_pkg::line_t            biu_d_i
);

  import cache_pkg::*;

  ////////////////////////////////////////////////////////////
  // types and signals
  ////////////////////////////////////////////////////////////

  // miss wait also covers the refill return
  // the word goes out on the ack edge
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    COMPARE,
    MISS_WAIT
  } state_e;

  state_e                state_q;
  state_e                state_d;

  // accepted request held until the word returns
  core_req_t             req_q;

  logic                  accept;
  logic                  hit_ret;
  logic                  fill_go;

  // one-hot round robin victim per set
  way_sel_t [SETS-1:0]   victim_q;

  // pick one word out of a line
  function automatic logic [XLEN-1:0] line_word(line_t line,
                                                logic [WORD_SEL_BITS-1:0] sel);
    return line[sel*XLEN +: XLEN];
  endfunction

  ////////////////////////////////////////////////////////////
  // request accept and lookup
  ////////////////////////////////////////////////////////////

  assign busy_o  = (state_q != IDLE);
  assign accept  = req_i & ~busy_o;

  // ram is read on the accept edge itself
  assign lookup_o = busy_o ? req_q : to_core_req(addr_i);

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      req_q <= to_core_req(addr_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////

  // hit_i is valid in compare only
  assign hit_ret = (state_q == COMPARE) & hit_i;

  // bus request as soon as the miss shows up
  assign biu_req_o  = ((state_q == COMPARE) & ~hit_i) | (state_q == MISS_WAIT);
  assign biu_addr_o = {req_q.tag, req_q.idx, {OFFS_BITS{1'b0}}};
  assign fill_go    = biu_req_o & biu_ack_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (accept) state_d = LOOKUP;
      LOOKUP:    state_d = COMPARE;
      COMPARE:   state_d = (hit_i | fill_go) ? IDLE : MISS_WAIT;
      MISS_WAIT: if (fill_go) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // read data return
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rvalid_o <= 1'b0;
    end
    else
    begin
      rvalid_o <= hit_ret | fill_go;
    end
  end

  // miss path takes the word straight off the bus
  always_ff @(posedge clk_i)
  begin
    if (fill_go)
    begin
      rdata_o <= line_word(biu_d_i, req_q.word_sel);
    end
    else if (hit_ret)
    begin
      rdata_o <= line_word(line_i, req_q.word_sel);
    end
  end

  ////////////////////////////////////////////////////////////
  // fill command and victim pointers
  ////////////////////////////////////////////////////////////

  assign fill_o.strobe = fill_go;
  assign fill_o.way    = victim_q[req_q.idx];
  assign fill_o.idx    = req_q.idx;
  assign fill_o.tag    = req_q.tag;

  // rotate the set's pointer after each fill
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      victim_q <= {SETS{way_sel_t'(1)}};
    end
    else if (flush_i && !busy_o)
    begin
      victim_q <= {SETS{way_sel_t'(1)}};
    end
    else if (fill_go)
    begin
      victim_q[req_q.idx] <= {victim_q[req_q.idx][WAYS-2:0],
                              victim_q[req_q.idx][WAYS-1]};
    end
  end

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,

  // core side
  input  wire logic                        req_i,
  input  wire logic [cache_pkg::XLEN-1:0]  addr_i,
  input  wire logic                        flush_i,
  output      logic                        busy_o,
  output      logic                        rvalid_o,
  output      logic [cache_pkg::XLEN-1:0]  rdata_o,

  // bus side
  output      logic                        biu_req_o,
  output      logic [cache_pkg::XLEN-1:0]  biu_addr_o,
  input  wire logic                        biu_ack_i,
  input  wire cache_pkg::line_t            biu_d_i
);

  import cache_pkg::*;

  ////////////////////////////////////////////////////////////
  // controller to cache memory
  ////////////////////////////////////////////////////////////

  core_req_t lookup;
  fill_t     fill;
  logic      hit;
  line_t     line;

  cache_ctrl u_cache_ctrl (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .req_i      ( req_i      ),
    .addr_i     ( addr_i     ),
    .flush_i    ( flush_i    ),
    .busy_o     ( busy_o     ),
    .rvalid_o   ( rvalid_o   ),
    .rdata_o    ( rdata_o    ),
    .lookup_o   ( lookup     ),
    .fill_o     ( fill       ),
    .hit_i      ( hit        ),
    .line_i     ( line       ),
    .biu_req_o  ( biu_req_o  ),
    .biu_addr_o ( biu_addr_o ),
    .biu_ack_i  ( biu_ack_i  ),
    .biu_d_i    ( biu_d_i    )
  );

  // fill data comes straight from the bus
  // hit way not needed by the controller
  cache_memory u_cache_memory (
    .clk_i       ( clk_i   ),
    .rst_ni      ( rst_ni  ),
    .lookup_i    ( lookup  ),
    .fill_i      ( fill    ),
    .fill_line_i ( biu_d_i ),
    .flush_i     ( flush_i ),
    .hit_o       ( hit     ),
    .hit_way_o   (         ),
    .line_o      ( line    )
  );

endmodule

`default_nettype wire

//--- verif/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  import cache_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RAND_REQS      = 300;

  // one accepted read waiting for its word
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            hit;
    logic [31:0]     cyc;
  } pend_t;

  logic            clk_i;
  logic            rst_ni;
  logic            req_i;
  logic [XLEN-1:0] addr_i;
  logic            flush_i;
  logic            busy_o;
  logic            rvalid_o;
  logic [XLEN-1:0] rdata_o;
  logic            biu_req_o;
  logic [XLEN-1:0] biu_addr_o;
  logic            biu_ack_i;
  line_t           biu_d_i;

  int    cycle_cnt = 0;
  int    error_cnt = 0;
  int    check_cnt = 0;
  int    timeout_cnt = 0;
  int    rsp_cnt = 0;
  bit    aborted = 1'b0;
  bit    saw_biu;
  pend_t pend_q [$];

  // model state indexed way by set
  bit    model_valid [WAYS][SETS];
  tag_t  model_tag   [WAYS][SETS];
  int    model_ptr   [SETS];

  cache_top u_cache_top (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .req_i      ( req_i      ),
    .addr_i     ( addr_i     ),
    .flush_i    ( flush_i    ),
    .busy_o     ( busy_o     ),
    .rvalid_o   ( rvalid_o   ),
    .rdata_o    ( rdata_o    ),
    .biu_req_o  ( biu_req_o  ),
    .biu_addr_o ( biu_addr_o ),
    .biu_ack_i  ( biu_ack_i  ),
    .biu_d_i    ( biu_d_i    )
  );

  ////////////////////////////////////////////////////////////
  // clock and cycle count
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #4;
      clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////

  // scrambled word per word address
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] x;
    x = {addr[XLEN-1:2], 2'b00} ^ 32'h5bd1e995;
    x = x ^ (x >> 15);
    x = x * 32'h2c1b3c6d;
    x = x ^ (x >> 12);
    return x + 32'h297a2d39;
  endfunction

  // word 0 of the line in the low bits
  function automatic line_t mem_line(input logic [XLEN-1:0] addr);
    line_t line;
    for (int i = 0; i < LINE_BITS / XLEN; i++)
    begin
      line[i*XLEN +: XLEN] = mem_word({addr[XLEN-1:OFFS_BITS], 4'h0} + 32'(i * 4));
    end
    return line;
  endfunction

  // hit or miss prediction with tag and round robin pointer update
  function automatic bit model_access(input logic [XLEN-1:0] addr);
    tag_t tag;
    idx_t idx;
    bit   hit;
    tag = addr[XLEN-1 -: TAG_BITS];
    idx = addr[OFFS_BITS +: IDX_BITS];
    hit = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (model_valid[w][idx] && model_tag[w][idx] == tag)
      begin
        hit = 1'b1;
      end
    end
    if (!hit)
    begin
      model_tag[model_ptr[idx]][idx]   = tag;
      model_valid[model_ptr[idx]][idx] = 1'b1;
      model_ptr[idx] = (model_ptr[idx] + 1) % WAYS;
    end
    return hit;
  endfunction

  function automatic void model_flush();
    for (int s = 0; s < SETS; s++)
    begin
      model_ptr[s] = 0;
      for (int w = 0; w < WAYS; w++)
      begin
        model_valid[w][s] = 1'b0;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    aborted = 1'b1;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((pend_q.size() != 0 || busy_o) && !aborted)
    begin
      if (n == TIMEOUT_CYCLES)
      begin
        report_timeout("read data never came back");
      end
      else
      begin
        next_cycle();
        n++;
      end
    end
  endtask

  // hold the request until an edge with busy_o low
  task automatic issue_read(input logic [XLEN-1:0] addr);
    int    n;
    pend_t entry;
    if (!aborted)
    begin
      req_i  = 1'b1;
      addr_i = addr;
      n      = 0;
      while (busy_o && !aborted)
      begin
        if (n == TIMEOUT_CYCLES)
        begin
          report_timeout("read request was never accepted");
        end
        else
        begin
          next_cycle();
          n++;
        end
      end
      if (!aborted)
      begin
        entry.addr = addr;
        entry.hit  = model_access(addr);
        entry.cyc  = 32'(cycle_cnt + 1);
        pend_q.push_back(entry);
        next_cycle();
      end
      req_i = 1'b0;
    end
  endtask

  task automatic flush_cache();
    wait_drain();
    if (!aborted)
    begin
      flush_i = 1'b1;
      next_cycle();
      flush_i = 1'b0;
      model_flush();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////

  // one cycle ack after 1 to 6 cycles
  initial
  begin : bus_model
    int bus_wait;
    biu_ack_i = 1'b0;
    biu_d_i   = '0;
    bus_wait  = 0;
    forever
    begin
      next_cycle();
      if (biu_ack_i)
      begin
        biu_ack_i = 1'b0;
      end
      else if (biu_req_o)
      begin
        if (bus_wait == 0)
        begin
          bus_wait = int'($urandom_range(1, 6));
        end
        bus_wait--;
        if (bus_wait == 0)
        begin
          biu_ack_i = 1'b1;
          biu_d_i   = mem_line(biu_addr_o);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////

  // outputs sampled mid cycle
  initial
  begin : monitor
    pend_t cur;
    int    ack_cyc;
    saw_biu = 1'b0;
    ack_cyc = 0;
    forever
    begin
      @(negedge clk_i);
      if (biu_req_o)
      begin
        saw_biu = 1'b1;
        if (pend_q.size() == 0)
        begin
          error_cnt++;
          $display("Bus request at %0t while no read was pending", $time);
        end
        else
        begin
          check_value("biu_addr_o", biu_addr_o,
                      {pend_q[0].addr[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}});
        end
      end
      // rvalid_o is due one cycle after the ack
      if (biu_ack_i)
      begin
        ack_cyc = cycle_cnt;
      end
      if (rvalid_o)
      begin
        if (pend_q.size() == 0)
        begin
          error_cnt++;
          $display("Read data at %0t while no read was pending", $time);
        end
        else
        begin
          cur = pend_q.pop_front();
          rsp_cnt++;
          check_value("rdata_o", rdata_o, mem_word(cur.addr));
          check_value("biu_req_o during read", 32'(saw_biu), 32'(!cur.hit));
          check_value("busy_o with rvalid_o", 32'(busy_o), 32'(0));
          if (cur.hit)
          begin
            check_value("hit latency", 32'(cycle_cnt) - cur.cyc, 32'(2));
          end
          else
          begin
            check_value("rvalid_o after biu_ack_i", 32'(cycle_cnt - ack_cyc), 32'(1));
          end
        end
        saw_biu = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    void'($urandom(32'hf917));
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    addr_i  = '0;
    flush_i = 1'b0;
    model_flush();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // quiet outputs out of reset
    check_value("busy_o", 32'(busy_o), 32'(0));
    check_value("rvalid_o", 32'(rvalid_o), 32'(0));
    check_value("biu_req_o", 32'(biu_req_o), 32'(0));

    // cold miss and then hits on words of the same line
    issue_read(32'h0000_1234);
    issue_read(32'h0000_1238);
    issue_read(32'h0000_1230);
    issue_read(32'h0000_2004);
    issue_read(32'h0000_2008);
    wait_drain();

    // three tags on set 5 where the third evicts the first
    issue_read(32'h0001_0050);
    issue_read(32'h0002_0054);
    issue_read(32'h0003_0058);
    issue_read(32'h0001_005c);
    // the two resident tags
    issue_read(32'h0003_0050);
    issue_read(32'h0001_0054);
    wait_drain();

    // everything misses again after flush
    flush_cache();
    issue_read(32'h0000_1234);
    issue_read(32'h0000_2004);
    issue_read(32'h0003_0050);
    wait_drain();

    // mostly back to back random reads over 1 KiB
    for (int i = 0; i < RAND_REQS; i++)
    begin
      issue_read(32'h0000_4000 + ($urandom_range(0, 255) << 2));
      if ($urandom_range(0, 7) == 0)
      begin
        repeat ($urandom_range(1, 4)) next_cycle();
      end
    end
    wait_drain();

    $display("reads %0d, checks %0d, errors %0d, timeouts %0d",
             rsp_cnt, check_cnt, error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
logic/cache_pkg.sv
logic/cache_ram_1rw.sv
logic/cache_memory.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sim.f --top-module cache_tb -o cache_sim || exit 1

out="$(./obj_dir/cache_sim 2>&1)"
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q '^RESULT: PASS$' && exit 0 || exit 1
